/* vlog.f */
+incdir+rtl
rtl/mvau_pkg.sv
rtl/mvau_control_block.sv
rtl/mvau_weight_mem.sv
rtl/mvau_input_buffer.sv
rtl/mvau_pe_array.sv
rtl/mvau_top.sv
dv/mvau_clk_gen.sv
dv/mvau_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mvau testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module mvau_tb -f vlog.f -o mvau_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/mvau_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
   echo "simulation reported a failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

exit 0

/* dv/mvau_tb.sv */
////////////////////////////////////////////////////////////
// mvau testbench
// weight load, random/extreme/gapped vectors, dot product
// reference model, output comparison and cycle timeout
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mvau_cfg.svh"

module mvau_tb
   import mvau_pkg::*;
();

   localparam int MW      = `MVAU_MW;
   localparam int MH      = `MVAU_MH;
   localparam int SIMD    = `MVAU_SIMD;
   localparam int PE      = `MVAU_PE;
   localparam int SF      = `MVAU_SF;
   localparam int NF      = `MVAU_NF;
   localparam int DEPTH   = `MVAU_WMEM_DEPTH;
   localparam int ABW     = `MVAU_WMEM_ADDR_BW;
   // vector counts per phase, gapped phase waits up to MAX_GAP cycles per word
   localparam int MAX_GAP   = 5;
   localparam int N_RAND    = 24;
   localparam int N_EXTREME = 3;
   localparam int N_GAP     = 24;
   localparam int N_VEC     = N_RAND + N_EXTREME + N_GAP;
   // worst case per vector is the gapped fill plus the full replay
   localparam int VEC_CYCLES  = SF * (MAX_GAP + 1) + SF * NF + 4;
   localparam int LOAD_CYCLES = 3 * (DEPTH + 2);
   localparam int MAX_CYCLES  = N_VEC * VEC_CYCLES + LOAD_CYCLES + 100;

   logic                    aclk;
   logic                    aresetn;
   logic                    wmem_we;
   logic [ABW-1:0]          wmem_waddr;
   wgt_t [PE-1:0][SIMD-1:0] wmem_wdata;
   logic                    in_v;
   act_t [SIMD-1:0]         in_data;
   logic                    in_wait;
   logic                    out_v;
   acc_t [PE-1:0]           out_data;

   // reference copy of the weight matrix, row major
   int w_ref [MH][MW];
   // expected results and their rows, PE entries per out_v
   int exp_q [$];
   int row_q [$];
   int pulse_cnt = 0;
   int low_cnt   = 0;
   int cycle_cnt = 0;

   mvau_clk_gen #(
      .PERIOD_NS    (8.0),
      .RESET_CYCLES (3)
   ) u_clk_gen (
      .aclk    (aclk),
      .aresetn (aresetn)
   );

   mvau_top u_mvau_top (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .wmem_we    (wmem_we),
      .wmem_waddr (wmem_waddr),
      .wmem_wdata (wmem_wdata),
      .in_v       (in_v),
      .in_data    (in_data),
      .in_wait    (in_wait),
      .out_v      (out_v),
      .out_data   (out_data)
   );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // uniform value over the full signed range of a width
   function automatic int rand_signed(input int width);
      return int'($urandom_range(32'((1 << width) - 1), 0)) - (1 << (width - 1));
   endfunction

   // row dot product in plain integer arithmetic
   function automatic int mvau_ref(input int vec[MW], input int row);
      int sum;
      sum = 0;
      for (int c = 0; c < MW; c++) begin
         sum += w_ref[row][c] * vec[c];
      end
      return sum;
   endfunction

   // address nf*SF+sf holds rows nf*PE.. and columns sf*SIMD..
   task automatic load_weights();
      for (int nf = 0; nf < NF; nf++) begin
         for (int sf = 0; sf < SF; sf++) begin
            @(posedge aclk);
            wmem_we    <= 1'b1;
            wmem_waddr <= ABW'(nf * SF + sf);
            for (int p = 0; p < PE; p++) begin
               for (int s = 0; s < SIMD; s++) begin
                  wmem_wdata[p][s] <= wgt_t'(w_ref[nf * PE + p][sf * SIMD + s]);
               end
            end
         end
      end
      @(posedge aclk);
      wmem_we <= 1'b0;
   endtask

   task automatic randomize_weights();
      for (int r = 0; r < MH; r++) begin
         for (int c = 0; c < MW; c++) begin
            w_ref[r][c] = rand_signed(`MVAU_WGT_W);
         end
      end
   endtask

   // SF words, optional idle gap before each, then queue the NF expected folds
   task automatic send_vector(input int vec[MW], input int max_gap);
      int gap;
      for (int sf = 0; sf < SF; sf++) begin
         gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
         repeat (gap) begin
            @(posedge aclk);
            in_v <= 1'b0;
         end
         // previous vector may still be replaying
         @(negedge aclk);
         while (!in_wait) begin
            @(posedge aclk);
            in_v <= 1'b0;
            @(negedge aclk);
         end
         @(posedge aclk);
         in_v <= 1'b1;
         for (int s = 0; s < SIMD; s++) begin
            in_data[s] <= act_t'(vec[sf * SIMD + s]);
         end
      end
      @(posedge aclk);
      in_v <= 1'b0;
      for (int r = 0; r < MH; r++) begin
         exp_q.push_back(mvau_ref(vec, r));
         row_q.push_back(r);
      end
   endtask

   task automatic wait_drained();
      @(negedge aclk);
      while (exp_q.size() != 0) begin
         @(negedge aclk);
      end
      repeat (2) @(posedge aclk);
   endtask

   // compare each fold result against the queued reference rows
   always @(negedge aclk) begin
      int got;
      int exp_val;
      int row;
      if (aresetn && out_v) begin
         assert (exp_q.size() >= PE) else
            report_failure("out_v pulsed while no vector result was pending");
         for (int p = 0; p < PE; p++) begin
            exp_val = exp_q.pop_front();
            row     = row_q.pop_front();
            got     = int'(out_data[p]);
            assert (got == exp_val) else
               report_failure($sformatf("Error at %0t: row %0d lane %0d got %0d expected %0d",
                  $time, row, p, got, exp_val));
         end
         pulse_cnt++;
      end
   end

   // in_wait low span is the replay, exactly SF*NF cycles
   always @(negedge aclk) begin
      if (!aresetn) begin
         low_cnt = 0;
      end else begin
         assert (in_wait || !in_v) else
            report_failure("in_v was driven while the input buffer was replaying");
         if (!in_wait) begin
            low_cnt++;
         end else begin
            if (low_cnt != 0) begin
               assert (low_cnt == SF * NF) else
                  report_failure($sformatf("Error at %0t: in_wait low for %0d cycles, expected %0d",
                     $time, low_cnt, SF * NF));
            end
            low_cnt = 0;
         end
      end
   end

   always @(posedge aclk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         report_failure($sformatf("timeout, run did not finish within %0d cycles", MAX_CYCLES));
      end
   end

   initial begin
      int vec [MW];
      void'($urandom(32'hc75cadf1));
      wmem_we    = 1'b0;
      wmem_waddr = '0;
      wmem_wdata = '0;
      in_v       = 1'b0;
      in_data    = '0;

      wait (aresetn === 1'b1);
      @(negedge aclk);
      assert (in_wait && !out_v) else
         report_failure("buffer not ready or output active right after reset");

      // random weights, back to back random vectors
      randomize_weights();
      load_weights();
      for (int i = 0; i < N_RAND; i++) begin
         for (int c = 0; c < MW; c++) begin
            vec[c] = rand_signed(`MVAU_ACT_W);
         end
         send_vector(vec, 0);
      end
      wait_drained();

      // full scale negative weights, min, max and alternating activations
      for (int r = 0; r < MH; r++) begin
         for (int c = 0; c < MW; c++) begin
            w_ref[r][c] = -(1 << (`MVAU_WGT_W - 1));
         end
      end
      load_weights();
      for (int i = 0; i < N_EXTREME; i++) begin
         for (int c = 0; c < MW; c++) begin
            if (i == 0 || (i == 2 && c % 2 == 0)) begin
               vec[c] = -(1 << (`MVAU_ACT_W - 1));
            end else begin
               vec[c] = (1 << (`MVAU_ACT_W - 1)) - 1;
            end
         end
         send_vector(vec, 0);
      end
      wait_drained();

      // new weights, words spaced by random idle cycles
      randomize_weights();
      load_weights();
      for (int i = 0; i < N_GAP; i++) begin
         for (int c = 0; c < MW; c++) begin
            vec[c] = rand_signed(`MVAU_ACT_W);
         end
         send_vector(vec, MAX_GAP);
      end
      wait_drained();

      if (exp_q.size() == 0 && pulse_cnt == N_VEC * NF) begin
         $display("test passed");
         $finish;
      end else begin
         $display("Error at %0t: %0d results pending, %0d pulses seen, %0d expected",
            $time, exp_q.size(), pulse_cnt, N_VEC * NF);
         $display("test failed");
         $fatal(1, "result count mismatch at end of run");
      end
   end

endmodule

/* dv/mvau_clk_gen.sv */
////////////////////////////////////////////////////////////
// testbench clock and reset source
// free running clock, active low reset held a few cycles
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mvau_clk_gen #(
   parameter real PERIOD_NS    = 8.0,
   parameter int  RESET_CYCLES = 3
) (
   output logic aclk,
   output logic aresetn
);

   initial begin
      aclk = 1'b0;
      forever #(PERIOD_NS / 2.0) aclk = ~aclk;
   end

   // released on a rising edge, same as every other input
   initial begin
      aresetn = 1'b0;
      repeat (RESET_CYCLES) @(posedge aclk);
      aresetn <= 1'b1;
   end

endmodule

/* rtl/mvau_top.sv */
////////////////////////////////////////////////////////////
// mvau top level
// input buffer, control block, weight memory and PE array
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mvau_cfg.svh"

module mvau_top
   import mvau_pkg::*;
(
   input  logic                                   aclk,
   input  logic                                   aresetn,
   // weight load port
   input  logic                                   wmem_we,
   input  logic [`MVAU_WMEM_ADDR_BW-1:0]          wmem_waddr,
   input  wgt_t [`MVAU_PE-1:0][`MVAU_SIMD-1:0]    wmem_wdata,
   // activation input, one word per in_v
   input  logic                                   in_v,
   input  act_t [`MVAU_SIMD-1:0]                  in_data,
   output logic                                   in_wait,
   // PE results, one pulse per row fold
   output logic                                   out_v,
   output acc_t [`MVAU_PE-1:0]                    out_data
);

   logic                                do_mvau;
   act_t [`MVAU_SIMD-1:0]               buf_data;
   logic                                wmem_valid;
   logic [`MVAU_WMEM_ADDR_BW-1:0]       wmem_addr;
   wgt_t [`MVAU_PE-1:0][`MVAU_SIMD-1:0] wmem_rdata;

   mvau_input_buffer u_input_buffer (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .in_v     (in_v),
      .in_data  (in_data),
      .in_wait  (in_wait),
      .do_mvau  (do_mvau),
      .buf_data (buf_data)
   );

   // buffer compute level gates the address walk
   mvau_control_block #(
      .SF           (`MVAU_SF),
      .NF           (`MVAU_NF),
      .WMEM_DEPTH   (`MVAU_WMEM_DEPTH),
      .WMEM_ADDR_BW (`MVAU_WMEM_ADDR_BW)
   ) u_control_block (
      .aclk        (aclk),
      .aresetn     (aresetn),
      .wmem_wready (do_mvau),
      .wmem_valid  (wmem_valid),
      .wmem_addr   (wmem_addr)
   );

   mvau_weight_mem u_weight_mem (
      .aclk  (aclk),
      .we    (wmem_we),
      .waddr (wmem_waddr),
      .wdata (wmem_wdata),
      .raddr (wmem_addr),
      .rdata (wmem_rdata)
   );

   mvau_pe_array u_pe_array (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .wmem_valid (wmem_valid),
      .wgt        (wmem_rdata),
      .act        (buf_data),
      .out_v      (out_v),
      .out_data   (out_data)
   );

endmodule

/* rtl/mvau_pe_array.sv */
////////////////////////////////////////////////////////////
// mvau PE array
// PE lanes of SIMD signed MACs, fold accumulators, out pulse
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mvau_cfg.svh"

module mvau_pe_array
   import mvau_pkg::*;
(
   input  logic                                   aclk,
   input  logic                                   aresetn,
   input  logic                                   wmem_valid,
   input  wgt_t [`MVAU_PE-1:0][`MVAU_SIMD-1:0]    wgt,
   input  act_t [`MVAU_SIMD-1:0]                  act,
   output logic                                   out_v,
   output acc_t [`MVAU_PE-1:0]                    out_data
);

   localparam int SF_BW = (`MVAU_SF > 1) ? $clog2(`MVAU_SF) : 1;
   localparam logic [SF_BW-1:0] LAST_SF = SF_BW'(`MVAU_SF - 1);

   logic                 prod_v;
   logic [SF_BW-1:0]     pe_sf;
   acc_t [`MVAU_PE-1:0]  lane_sum;
   acc_t [`MVAU_PE-1:0]  fold_sum;
   acc_t [`MVAU_PE-1:0]  acc;

   // per lane sum of SIMD products, all in signed acc width
   always_comb begin
      act_t a;
      wgt_t w;
      acc_t prod;
      for (int p = 0; p < `MVAU_PE; p++) begin
         lane_sum[p] = '0;
         for (int s = 0; s < `MVAU_SIMD; s++) begin
            a           = act[s];
            w           = wgt[p][s];
            prod        = a * w;
            lane_sum[p] = lane_sum[p] + prod;
         end
         // first word of a fold restarts the sum
         fold_sum[p] = (pe_sf == '0) ? lane_sum[p] : acc[p] + lane_sum[p];
      end
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         prod_v <= 1'b0;
         pe_sf  <= '0;
         out_v  <= 1'b0;
         acc    <= '0;
      end else begin
         // memory and buffer both add one cycle of latency
         prod_v <= wmem_valid;
         out_v  <= 1'b0;
         if (prod_v) begin
            acc <= fold_sum;
            if (pe_sf == LAST_SF) begin
               pe_sf <= '0;
               out_v <= 1'b1;
            end else begin
               pe_sf <= pe_sf + 1'b1;
            end
         end
      end
   end

   // result held until the next fold completes
   always_ff @(posedge aclk) begin
      if (prod_v && pe_sf == LAST_SF) begin
         out_data <= fold_sum;
      end
   end

   // a fold runs on consecutive cycles, so out_v pulses stay SF cycles apart
   if (`MVAU_SF > 1) begin : g_pulse_check
      a_fold_unbroken : assert property (@(posedge aclk) disable iff (!aresetn)
         prod_v && pe_sf != LAST_SF |=> prod_v);
   end

endmodule

/* rtl/mvau_input_buffer.sv */
////////////////////////////////////////////////////////////
// mvau input buffer
// fill/compute FSM, stores SF words and replays them NF times
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mvau_cfg.svh"

module mvau_input_buffer
   import mvau_pkg::*;
(
   input  logic                    aclk,
   input  logic                    aresetn,
   input  logic                    in_v,
   input  act_t [`MVAU_SIMD-1:0]   in_data,
   output logic                    in_wait,
   output logic                    do_mvau,
   output act_t [`MVAU_SIMD-1:0]   buf_data
);

   // counter widths, kept at least one bit for the single fold case
   localparam int SF_BW = (`MVAU_SF > 1) ? $clog2(`MVAU_SF) : 1;
   localparam int NF_BW = (`MVAU_NF > 1) ? $clog2(`MVAU_NF) : 1;
   localparam logic [SF_BW-1:0] LAST_SF = SF_BW'(`MVAU_SF - 1);
   localparam logic [NF_BW-1:0] LAST_NF = NF_BW'(`MVAU_NF - 1);

   buf_state_t          state;
   logic [SF_BW-1:0]    fill_idx;
   logic [SF_BW-1:0]    sf_cnt;
   logic [NF_BW-1:0]    nf_cnt;
   act_t [`MVAU_SIMD-1:0] buf_mem [`MVAU_SF];

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state    <= ST_FILL;
         fill_idx <= '0;
         sf_cnt   <= '0;
         nf_cnt   <= '0;
      end else begin
         unique case (state)
            ST_FILL: begin
               // count words until the whole vector is in
               if (in_v) begin
                  if (fill_idx == LAST_SF) begin
                     fill_idx <= '0;
                     state    <= ST_COMPUTE;
                  end else begin
                     fill_idx <= fill_idx + 1'b1;
                  end
               end
            end
            ST_COMPUTE: begin
               // sf is the inner loop, nf the outer one
               if (sf_cnt == LAST_SF) begin
                  sf_cnt <= '0;
                  if (nf_cnt == LAST_NF) begin
                     nf_cnt <= '0;
                     state  <= ST_FILL;
                  end else begin
                     nf_cnt <= nf_cnt + 1'b1;
                  end
               end else begin
                  sf_cnt <= sf_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   // word storage and replay, data path only
   always_ff @(posedge aclk) begin
      if (state == ST_FILL && in_v) begin
         buf_mem[fill_idx] <= in_data;
      end
      // one cycle behind sf_cnt, same as the weight read
      buf_data <= buf_mem[sf_cnt];
   end

   assign in_wait = (state == ST_FILL);
   // drives the control block for SF*NF cycles per vector
   assign do_mvau = (state == ST_COMPUTE);

   // the source must hold off while the vector is replayed
   a_no_input_in_compute : assert property (@(posedge aclk) disable iff (!aresetn)
      state == ST_COMPUTE |-> !in_v);

endmodule

/* rtl/mvau_weight_mem.sv */
////////////////////////////////////////////////////////////
// mvau weight memory
// simple dual port, external write, registered PExSIMD read
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mvau_cfg.svh"

module mvau_weight_mem
   import mvau_pkg::*;
(
   input  logic                                         aclk,
   // write port, loaded before the first vector
   input  logic                                         we,
   input  logic [`MVAU_WMEM_ADDR_BW-1:0]                waddr,
   input  wgt_t [`MVAU_PE-1:0][`MVAU_SIMD-1:0]          wdata,
   // read port, data one cycle after the address
   input  logic [`MVAU_WMEM_ADDR_BW-1:0]                raddr,
   output wgt_t [`MVAU_PE-1:0][`MVAU_SIMD-1:0]          rdata
);

   // one word holds SIMD weights for each of the PE rows
   wgt_t [`MVAU_PE-1:0][`MVAU_SIMD-1:0] mem [`MVAU_WMEM_DEPTH];

   // write side
   always_ff @(posedge aclk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // read side, registered so it lines up with the buffer word
   always_ff @(posedge aclk) begin
      rdata <= mem[raddr];
   end

endmodule

/* rtl/mvau_control_block.sv */
////////////////////////////////////////////////////////////
// mvau control block
// weight memory read address counter and weight valid level
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mvau_control_block #(
   parameter int SF           = 4,
   parameter int NF           = 4,
   parameter int WMEM_DEPTH   = 16,
   parameter int WMEM_ADDR_BW = 4
) (
   input  logic                    aclk,
   input  logic                    aresetn,
   input  logic                    wmem_wready,
   output logic                    wmem_valid,
   output logic [WMEM_ADDR_BW-1:0] wmem_addr
);

   // every (nf, sf) pair owns exactly one weight word
   if (WMEM_DEPTH != SF * NF) begin : g_depth_check
      $error("weight memory depth does not match SF*NF");
   end

   if (WMEM_DEPTH == 1) begin : g_one_word
      // single word, address pinned to zero
      always_ff @(posedge aclk) begin
         if (!aresetn) begin
            wmem_addr <= '0;
         end else if (wmem_wready) begin
            wmem_addr <= '0;
         end
      end
   end else begin : g_multi_word
      // walk the memory once per vector, wrap on the last word
      always_ff @(posedge aclk) begin
         if (!aresetn) begin
            wmem_addr <= '0;
         end else if (wmem_wready) begin
            if (wmem_addr == WMEM_ADDR_BW'(WMEM_DEPTH - 1)) begin
               wmem_addr <= '0;
            end else begin
               wmem_addr <= wmem_addr + 1'b1;
            end
         end
      end
   end

   // weights are valid on every cycle the buffer is computing
   assign wmem_valid = wmem_wready;

   // address is back at word 0 whenever the buffer is not computing
   a_addr_idle_at_zero : assert property (@(posedge aclk) disable iff (!aresetn)
      !wmem_wready |-> wmem_addr == '0);

endmodule

/* rtl/mvau_pkg.sv */
////////////////////////////////////////////////////////////
// mvau types
// input buffer state and signed element/accumulator types
////////////////////////////////////////////////////////////
`include "mvau_cfg.svh"

package mvau_pkg;

   // input buffer is either taking words or replaying them
   typedef enum logic {
      ST_FILL    = 1'b0,
      ST_COMPUTE = 1'b1
   } buf_state_t;

   // one activation from the input stream
   typedef logic signed [`MVAU_ACT_W-1:0] act_t;
   // one weight from the weight memory
   typedef logic signed [`MVAU_WGT_W-1:0] wgt_t;
   // dot product accumulator, wide enough for MW full-scale products
   typedef logic signed [`MVAU_ACC_W-1:0] acc_t;

endpackage

/* rtl/mvau_cfg.svh */
////////////////////////////////////////////////////////////
// mvau configuration macros
// matrix size, folding factors, memory depth and word widths
////////////////////////////////////////////////////////////
`ifndef MVAU_CFG_SVH
`define MVAU_CFG_SVH

// matrix columns, also the input vector length
`define MVAU_MW 16
// matrix rows, also the output vector length
`define MVAU_MH 8
// activations per input word
`define MVAU_SIMD 4
// rows computed in parallel
`define MVAU_PE 2

// column folds and row folds
`define MVAU_SF (`MVAU_MW / `MVAU_SIMD)
`define MVAU_NF (`MVAU_MH / `MVAU_PE)

// one weight word per (nf, sf) pair
`define MVAU_WMEM_DEPTH (`MVAU_SF * `MVAU_NF)
`define MVAU_WMEM_ADDR_BW 4

// element widths, all signed
`define MVAU_ACT_W 4
`define MVAU_WGT_W 4
`define MVAU_ACC_W 16

`endif
